//--- adc_capture.f
src/adc_lane_pkg.sv
src/iq_sample_pkg.sv
src/lane_deserializer.sv
src/frame_recapture.sv
src/iq_mapper.sv
src/adc_capture_top.sv
test/adc_capture_checker.sv
test/adc_capture_tb.sv

//--- Makefile
VERILATOR ?= verilator
TOP       ?= adc_capture_tb
FILELIST  ?= adc_capture.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing --assert
LINTFLAGS ?= --lint-only --timing --assert
PASS_MSG  ?= Finished with no errors

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR) -o V$(TOP)

run: build
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR)

//--- test/adc_capture_testdata.txt
// Columns (hex): test valid sync lane0 lane1 lane2 lane3, one record per cycle
// Closing line: test number 0, then the expected number of bundles
// Test 1, idle with junk words, sync high on an invalid cycle
1 0 0 3fff 2aaa 1555 0f0f
1 0 1 1234 2345 3456 0567
1 0 0 0abc 1bcd 2cde 3def
1 0 0 3001 2002 1003 0004
// Test 2, two frames back to back
2 1 0 0101 0201 0301 0401
2 1 0 0102 0202 0302 0402
2 1 0 0103 0203 0303 0403
2 1 0 0104 0204 0304 0404
2 1 0 0a11 0b21 0c31 0d41
2 1 0 0a12 0b22 0c32 0d42
2 1 0 0a13 0b23 0c33 0d43
2 1 0 0a14 0b24 0c34 0d44
// Test 3, gaps inside one frame
3 1 0 0311 0321 0331 0341
3 0 0 3eee 3eee 3eee 3eee
3 1 0 0312 0322 0332 0342
3 1 0 0313 0323 0333 0343
3 0 0 3ddd 3ddd 3ddd 3ddd
3 1 0 0314 0324 0334 0344
// Test 4, info bits rotate per lane and word
4 1 0 0041 1042 2043 3044
4 1 0 1051 2052 3053 0054
4 1 0 2061 3062 0063 1064
4 1 0 3071 0072 1073 2074
// Test 5, sync on the third word, then sync only during a gap
5 1 0 0501 0502 0503 0504
5 1 0 0511 0512 0513 0514
5 1 1 0521 0522 0523 0524
5 1 0 0531 0532 0533 0534
5 1 0 0541 0542 0543 0544
5 0 1 3fff 3fff 3fff 3fff
5 1 0 0551 0552 0553 0554
5 1 0 0561 0562 0563 0564
5 1 0 0571 0572 0573 0574
// Test 6, two more frames in flight, sync on a first word
6 1 0 1601 2602 3603 0604
6 1 0 2611 3612 0613 1614
6 1 0 3621 0622 1623 2624
6 1 0 0631 1632 2633 3634
6 1 1 3fff 0000 2aaa 1555
6 1 0 1111 2222 3333 0abc
6 1 0 0def 1fed 2cba 3210
6 1 0 3123 2234 1345 0456
0 8

//--- test/adc_capture_tb.sv
`default_nettype none

module adc_capture_tb;

    import adc_lane_pkg::*;
    import iq_sample_pkg::*;

    // --------------------------------------------------
    // Run constants
    // --------------------------------------------------
    localparam int    CLK_PERIOD   = 100;
    localparam int    RESET_CYCLES = 10;
    localparam int    DRAIN_CYCLES = 3;     // Quiet edges after the last bundle
    localparam int    REC_FIELDS   = 7;     // Test, valid, sync, four lane words
    localparam int    MEM_DEPTH    = 1024;
    localparam int    NUM_TESTS    = 6;
    localparam string DATA_FILE    = "test/adc_capture_testdata.txt";

    logic        clk_0;
    logic        rst_n;
    lane_words_t lane_in;
    logic        lane_valid;
    logic        sync_pps;
    iq_bundle_t  iq_out;
    logic        iq_valid;

    logic [31:0] tdata [0:MEM_DEPTH-1];  // Raw tokens from the data file
    int n_lines   = 0;                   // Stimulus records
    int exp_count = 0;                   // Bundle count from the closing line
    bit parsed    = 1'b0;
    bit running   = 1'b0;                // Output monitor enabled
    int cyc       = 0;                   // Rising edges so far

    // Reference model state
    lane_words_t acc_words [WORDS_PER_FRAME];
    int          acc_pos  = 0;
    logic        acc_sync = 1'b0;
    iq_bundle_t  exp_q [$];              // Expected bundles in order
    int          exp_cyc_q [$];          // Edge count at which each should show
    int          exp_tag_q [$];          // Test that produced each frame

    // Scoreboard
    int err_cnt     = 0;
    int chk_cnt     = 0;
    int pulse_cnt   = 0;
    int cur_test    = 1;
    bit seen_bundle = 1'b0;
    int test_errs    [1:NUM_TESTS];
    int test_bundles [1:NUM_TESTS];
    bit test_done    [1:NUM_TESTS];

    adc_capture_top u_adc_capture_top (
        .clk_0      (clk_0),
        .rst_n      (rst_n),
        .lane_in    (lane_in),
        .lane_valid (lane_valid),
        .sync_pps   (sync_pps),
        .iq_out     (iq_out),
        .iq_valid   (iq_valid)
    );

    // Assertions see the internal strobes of the top level
    bind adc_capture_top adc_capture_checker u_adc_capture_checker (
        .clk_0      (clk_0),
        .rst_n      (rst_n),
        .frame_done (frame_done),
        .held_done  (held_done),
        .held_frame (held_frame),
        .iq_out     (iq_out),
        .iq_valid   (iq_valid)
    );

    initial
    begin
        clk_0 = 1'b0;
        forever #(CLK_PERIOD / 2) clk_0 = ~clk_0;
    end

    always @(posedge clk_0) cyc <= cyc + 1;

    // --------------------------------------------------
    // Reference model
    // --------------------------------------------------
    function automatic string test_name(input int t);
        case (t)
            1:       return "idle after reset";
            2:       return "continuous valid";
            3:       return "valid gaps";
            4:       return "info fields";
            5:       return "sync flag";
            6:       return "bundle count";
            default: return "unknown";
        endcase
    endfunction

    // Top two bits are info and the low twelve are data
    function automatic iq_sample_t word_to_sample(input adc_word_t w);
        iq_sample_t s;
        s.info = w[13:12];
        s.data = w[11:0];
        return s;
    endfunction

    function automatic iq_bundle_t expected_bundle();
        iq_bundle_t b;
        b = '0;
        for (int w = 0; w < WORDS_PER_FRAME; w++)
        begin
            b.i_rail[w]     = word_to_sample(acc_words[w].lane[0]);  // I0..I3
            b.i_rail[w + 4] = word_to_sample(acc_words[w].lane[1]);  // I4..I7
            b.q_rail[w]     = word_to_sample(acc_words[w].lane[2]);  // Q0..Q3
            b.q_rail[w + 4] = word_to_sample(acc_words[w].lane[3]);  // Q4..Q7
        end
        b.sync = acc_sync;
        return b;
    endfunction

    // Called at the falling edge before the accepting rising edge
    task automatic model_word(input lane_words_t words, input logic sync, input int tag);
        acc_words[acc_pos] = words;
        acc_sync = acc_sync | sync;
        acc_pos++;
        if (acc_pos == WORDS_PER_FRAME)
        begin
            exp_q.push_back(expected_bundle());
            exp_cyc_q.push_back(cyc + 3);            // Accept edge plus two
            exp_tag_q.push_back(tag);
            acc_pos  = 0;
            acc_sync = 1'b0;
        end
    endtask

    // --------------------------------------------------
    // Compare tasks
    // --------------------------------------------------
    task automatic log_error(input string msg);
        $display("[ERROR] t=%0t %s", $time, msg);
        err_cnt++;
        test_errs[cur_test]++;
    endtask

    task automatic check_sample(input iq_sample_t act, input iq_sample_t exp,
                                input string rail, input int idx);
        chk_cnt++;
        if (act !== exp)
            log_error($sformatf("%s[%0d] info/data %0h/%03h, expected %0h/%03h",
                                rail, idx, act.info, act.data, exp.info, exp.data));
    endtask

    task automatic check_bundle(input iq_bundle_t act, input iq_bundle_t exp);
        for (int i = 0; i < SAMPLES_PER_RAIL; i++)
        begin
            check_sample(act.i_rail[i], exp.i_rail[i], "I", i);
            check_sample(act.q_rail[i], exp.q_rail[i], "Q", i);
        end
        chk_cnt++;
        if (act.sync !== exp.sync)
            log_error($sformatf("sync %0b, expected %0b", act.sync, exp.sync));
    endtask

    task automatic check_latency(input int act, input int exp);
        chk_cnt++;
        if (act != exp)
            log_error($sformatf("iq_valid after edge %0d, expected edge %0d", act - 1, exp - 1));
    endtask

    task automatic check_count(input int act, input int exp);
        chk_cnt++;
        if (act != exp)
            log_error($sformatf("%0d iq_valid pulses, expected %0d", act, exp));
    endtask

    // --------------------------------------------------
    // Per test report
    // --------------------------------------------------
    task automatic finish_test(input int t);
        if (!test_done[t])
        begin
            test_done[t] = 1'b1;
            $display("Test %0d (%s): %0d bundles, %0d errors, %s", t, test_name(t),
                     test_bundles[t], test_errs[t], (test_errs[t] == 0) ? "PASS" : "FAIL");
        end
    endtask

    task automatic advance_to(input int t);
        while (cur_test < t)
        begin
            finish_test(cur_test);                   // Earlier test has drained
            cur_test++;
        end
    endtask

    // --------------------------------------------------
    // Stimulus
    // --------------------------------------------------
    task automatic apply_record(input int rec);
        int          base;
        lane_words_t words;
        base = rec * REC_FIELDS;
        for (int l = 0; l < NUM_LANES; l++)
            words.lane[l] = tdata[base + 3 + l][WORD_WIDTH-1:0];
        lane_in    = words;                          // Offered even when not valid
        lane_valid = tdata[base + 1][0];
        sync_pps   = tdata[base + 2][0];
        if (tdata[base + 1][0])
            model_word(words, tdata[base + 2][0], int'(tdata[base]));
    endtask

    initial
    begin
        int idx;
        bit found;
        idx        = 0;
        found      = 1'b0;
        lane_in    = '0;
        lane_valid = 1'b0;
        sync_pps   = 1'b0;
        rst_n      = 1'b0;
        $readmemh(DATA_FILE, tdata);
        // Records until a test number of zero, which holds the count
        while (!found && idx + 1 < MEM_DEPTH && !$isunknown(tdata[idx]))
        begin
            if (tdata[idx] == 0)
            begin
                found     = 1'b1;
                exp_count = int'(tdata[idx + 1]);
            end
            else
            begin
                n_lines++;
                idx += REC_FIELDS;
            end
        end
        if (!found || n_lines == 0)
        begin
            $display("Test data file is missing, holds no records or has no closing count line");
            $display("Finished with errors");
            $finish;
        end
        else
        begin
            parsed = 1'b1;
            repeat (RESET_CYCLES) @(negedge clk_0);
            rst_n = 1'b1;
            @(posedge clk_0);
            running = 1'b1;
            for (int r = 0; r < n_lines; r++)
            begin
                @(negedge clk_0);
                apply_record(r);
            end
            @(negedge clk_0);
            lane_valid = 1'b0;
            sync_pps   = 1'b0;
            lane_in    = '0;
            while (exp_q.size() != 0) @(posedge clk_0);  // Last frames still in the pipeline
            repeat (DRAIN_CYCLES) @(posedge clk_0);
            running = 1'b0;
            advance_to(NUM_TESTS);
            check_count(pulse_cnt, exp_count);
            finish_test(NUM_TESTS);
            $display("Summary: %0d checks, %0d bundles, %0d errors", chk_cnt, pulse_cnt, err_cnt);
            if (err_cnt == 0)
                $display("Finished with no errors");
            else
                $display("Finished with errors");
            $finish;
        end
    end

    // --------------------------------------------------
    // Output monitor at mid cycle
    // --------------------------------------------------
    always @(negedge clk_0)
    begin
        if (running)
        begin
            if (iq_valid === 1'b1)
            begin
                pulse_cnt++;
                if (exp_q.size() == 0)
                    log_error("iq_valid pulse with no frame expected");
                else
                begin
                    advance_to(exp_tag_q[0]);
                    test_bundles[cur_test]++;
                    check_latency(cyc, exp_cyc_q.pop_front());
                    check_bundle(iq_out, exp_q.pop_front());
                    void'(exp_tag_q.pop_front());
                    seen_bundle = 1'b1;
                end
            end
            else if (exp_q.size() != 0 && cyc > exp_cyc_q[0])
            begin
                advance_to(exp_tag_q[0]);
                log_error($sformatf("No iq_valid for the frame due after edge %0d",
                                    exp_cyc_q[0] - 1));
                void'(exp_q.pop_front());
                void'(exp_cyc_q.pop_front());
                void'(exp_tag_q.pop_front());
            end
            else if (!seen_bundle)
                check_bundle(iq_out, '0);            // Idle output stays cleared
        end
    end

    // Limit follows the length of the stimulus
    initial
    begin
        wait (parsed);
        #((n_lines + 20) * CLK_PERIOD);
        $display("Timeout: simulation did not complete within %0d cycles", n_lines + 20);
        $display("Finished with errors");
        $finish;
    end

endmodule

`default_nettype wire

//--- test/adc_capture_checker.sv
`default_nettype none

module adc_capture_checker (
    input logic                      clk_0,
    input logic                      rst_n,
    input logic                      frame_done,  // Deserializer strobe
    input logic                      held_done,   // Recapture strobe
    input adc_lane_pkg::adc_frame_t  held_frame,  // Recapture register
    input iq_sample_pkg::iq_bundle_t iq_out,      // Output bundle
    input logic                      iq_valid     // Output strobe
);

    // --------------------------------------------------
    // Strobe shape
    // --------------------------------------------------
    a_valid_single : assert property (@(posedge clk_0) disable iff (!rst_n)
        iq_valid |=> !iq_valid)
        else $error("iq_valid high on two consecutive cycles");

    a_valid_reset : assert property (@(posedge clk_0)
        !rst_n |-> !iq_valid)
        else $error("iq_valid high while reset is active");

    // Two register stages between frame_done and iq_valid
    a_done_to_valid : assert property (@(posedge clk_0) disable iff (!rst_n)
        $past(frame_done, 2) |-> iq_valid)
        else $error("frame_done not followed by iq_valid two cycles later");

    a_valid_from_done : assert property (@(posedge clk_0) disable iff (!rst_n)
        iq_valid |-> $past(frame_done, 2))
        else $error("iq_valid without a frame_done two cycles earlier");

    // --------------------------------------------------
    // Held data
    // --------------------------------------------------
    a_held_stable : assert property (@(posedge clk_0) disable iff (!rst_n)
        !held_done |-> $stable(held_frame))
        else $error("held_frame changed without a new frame");

    a_out_stable : assert property (@(posedge clk_0) disable iff (!rst_n)
        !iq_valid |-> $stable(iq_out))
        else $error("iq_out changed without iq_valid");

endmodule

`default_nettype wire

//--- src/adc_capture_top.sv
`default_nettype none

module adc_capture_top (
    input  logic                     clk_0,
    input  logic                     rst_n,
    input  adc_lane_pkg::lane_words_t lane_in,     // ADC word per lane
    input  logic                     lane_valid,  // Word valid level
    input  logic                     sync_pps,    // Pulse-per-second sync level
    output iq_sample_pkg::iq_bundle_t iq_out,      // I/Q samples of the last frame
    output logic                     iq_valid     // New bundle strobe
);

    import adc_lane_pkg::*;

    // --------------------------------------------------
    // Pipeline nets
    // --------------------------------------------------
    adc_frame_t frame;       // Deserializer output
    logic       frame_done;  // Cycle after the fourth word
    adc_frame_t held_frame;  // Recapture output
    logic       held_done;   // One cycle after frame_done

    // Collect four valid words per lane
    lane_deserializer u_lane_deserializer (
        .clk_0      (clk_0),
        .rst_n      (rst_n),
        .lane_in    (lane_in),
        .lane_valid (lane_valid),
        .sync_pps   (sync_pps),
        .frame      (frame),
        .frame_done (frame_done)
    );

    // Register the completed frame
    frame_recapture u_frame_recapture (
        .clk_0      (clk_0),
        .rst_n      (rst_n),
        .frame      (frame),
        .frame_done (frame_done),
        .held_frame (held_frame),
        .held_done  (held_done)
    );

    // Map lanes onto I and Q rails
    iq_mapper u_iq_mapper (
        .clk_0      (clk_0),
        .rst_n      (rst_n),
        .held_frame (held_frame),
        .held_done  (held_done),
        .iq_out     (iq_out),
        .iq_valid   (iq_valid)      // Two edges after frame completion
    );

endmodule

`default_nettype wire

//--- src/iq_mapper.sv
`default_nettype none

module iq_mapper (
    input  logic                     clk_0,
    input  logic                     rst_n,
    input  adc_lane_pkg::adc_frame_t  held_frame,  // Recaptured frame
    input  logic                     held_done,   // New frame in held_frame
    output iq_sample_pkg::iq_bundle_t iq_out,      // Most recent bundle
    output logic                     iq_valid     // One cycle pulse per bundle
);

    import adc_lane_pkg::*;
    import iq_sample_pkg::*;

    iq_bundle_t mapped;  // Combinational bundle from held_frame

    // Split one raw word into info and data fields
    function automatic iq_sample_t split_word(input adc_word_t word);
        iq_sample_t s;
        s.info = word[SAMPLE_WIDTH +: INFO_WIDTH];  // Bits 13 to 12
        s.data = word[SAMPLE_WIDTH-1:0];            // Bits 11 to 0
        return s;
    endfunction

    // --------------------------------------------------
    // Lane to rail mapping
    // --------------------------------------------------
    // Lane 0 -> I0..I3, lane 1 -> I4..I7
    // Lane 2 -> Q0..Q3, lane 3 -> Q4..Q7
    always_comb
    begin
        mapped = '0;
        for (int w = 0; w < WORDS_PER_FRAME; w++)
        begin
            mapped.i_rail[w]                   = split_word(held_frame.t[w].lane[0]);
            mapped.i_rail[w + WORDS_PER_FRAME] = split_word(held_frame.t[w].lane[1]);
            mapped.q_rail[w]                   = split_word(held_frame.t[w].lane[2]);
            mapped.q_rail[w + WORDS_PER_FRAME] = split_word(held_frame.t[w].lane[3]);
        end
        mapped.sync = held_frame.sync_seen;
    end

    // --------------------------------------------------
    // Output register
    // --------------------------------------------------
    always_ff @(posedge clk_0 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            iq_out   <= '0;
            iq_valid <= 1'b0;
        end
        else
        begin
            iq_valid <= held_done;           // Pulse lines up with the new bundle
            if (held_done)
            begin
                iq_out <= mapped;            // Held until the next frame
            end
        end
    end

endmodule

`default_nettype wire

//--- src/frame_recapture.sv
`default_nettype none

module frame_recapture (
    input  logic                    clk_0,
    input  logic                    rst_n,
    input  adc_lane_pkg::adc_frame_t frame,       // From the deserializer
    input  logic                    frame_done,  // Frame is complete this cycle
    output adc_lane_pkg::adc_frame_t held_frame,  // Stable copy for the mapper
    output logic                    held_done    // frame_done delayed one cycle
);

    // --------------------------------------------------
    // Recapture register
    // --------------------------------------------------
    // Re-times the frame onto a clean register stage ahead of the mapper
    // held_frame only changes when a new frame arrives
    always_ff @(posedge clk_0 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            held_frame <= '0;
        end
        else if (frame_done)
        begin
            held_frame <= frame;             // Words and sync flag together
        end
    end

    // Done pulse follows the data by exactly one stage
    always_ff @(posedge clk_0 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            held_done <= 1'b0;
        end
        else
        begin
            held_done <= frame_done;
        end
    end

endmodule

`default_nettype wire

//--- src/lane_deserializer.sv
`default_nettype none

module lane_deserializer (
    input  logic                     clk_0,
    input  logic                     rst_n,
    input  adc_lane_pkg::lane_words_t lane_in,     // One word per lane this cycle
    input  logic                     lane_valid,  // Accept lane_in on this edge
    input  logic                     sync_pps,    // Sync level, sampled with the words
    output adc_lane_pkg::adc_frame_t  frame,       // Last completed frame
    output logic                     frame_done   // One cycle pulse per frame
);

    import adc_lane_pkg::*;

    // --------------------------------------------------
    // Word position tracking
    // --------------------------------------------------
    localparam int POS_W = $clog2(WORDS_PER_FRAME);
    localparam logic [POS_W-1:0] LAST_POS = POS_W'(WORDS_PER_FRAME - 1);

    logic [POS_W-1:0]                   word_pos;  // Slot of the next accepted word
    logic                               last_word; // Current accept completes a frame
    lane_words_t [WORDS_PER_FRAME-2:0]  word_sr;   // Words t0 to t2 of the open frame
    logic                               sync_acc;  // Running sync OR for the open frame

    assign last_word = lane_valid && (word_pos == LAST_POS);

    // Position counter, skips cycles without valid
    always_ff @(posedge clk_0 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            word_pos <= '0;
        end
        else if (last_word)
        begin
            word_pos <= '0;                  // Next word starts a new frame
        end
        else if (lane_valid)
        begin
            word_pos <= word_pos + 1'b1;
        end
    end

    // Shift register, newest word enters at the top
    // After three shifts the oldest word sits in slot 0
    always_ff @(posedge clk_0 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            word_sr  <= '0;
            sync_acc <= 1'b0;
        end
        else if (lane_valid)
        begin
            word_sr  <= {lane_in, word_sr[WORDS_PER_FRAME-2:1]};
            // Flag restarts with every frame
            sync_acc <= last_word ? 1'b0 : (sync_acc | sync_pps);
        end
    end

    // --------------------------------------------------
    // Frame output
    // --------------------------------------------------
    // Fourth word goes straight into t3 with the three held ones below it
    always_ff @(posedge clk_0 or negedge rst_n)
    begin
        if (!rst_n)
        begin
            frame      <= '0;
            frame_done <= 1'b0;
        end
        else
        begin
            frame_done <= last_word;         // High the cycle after the fourth word
            if (last_word)
            begin
                frame.t         <= {lane_in, word_sr};
                frame.sync_seen <= sync_acc | sync_pps; // Include this edge's sync
            end
        end
    end

endmodule

`default_nettype wire

//--- src/iq_sample_pkg.sv
`default_nettype none

package iq_sample_pkg;

    // --------------------------------------------------
    // User side sample format
    // --------------------------------------------------
    localparam int SAMPLE_WIDTH     = 12;  // Data field, word bits 11 to 0
    localparam int INFO_WIDTH       = 2;   // Info field, word bits 13 to 12
    localparam int SAMPLES_PER_RAIL = 8;   // Samples per I or Q rail per bundle

    // One sample, info sits above data like in the raw word
    typedef struct packed {
        logic [INFO_WIDTH-1:0]   info;
        logic [SAMPLE_WIDTH-1:0] data;
    } iq_sample_t;

    // Full output bundle for one frame
    // I from lanes 0 and 1, Q from lanes 2 and 3
    typedef struct packed {
        iq_sample_t [SAMPLES_PER_RAIL-1:0] i_rail;  // I samples 0 to 7
        iq_sample_t [SAMPLES_PER_RAIL-1:0] q_rail;  // Q samples 0 to 7
        logic                              sync;    // Frame saw sync_pps
    } iq_bundle_t;

endpackage

`default_nettype wire

//--- src/adc_lane_pkg.sv
`default_nettype none

package adc_lane_pkg;

    // --------------------------------------------------
    // ADC lane geometry
    // --------------------------------------------------
    localparam int NUM_LANES       = 4;   // Parallel data lanes from the ADC
    localparam int WORDS_PER_FRAME = 4;   // Words collected per lane into one frame
    localparam int WORD_WIDTH      = 14;  // Raw lane word, info on top of data

    // One raw word as delivered on a single lane
    typedef logic [WORD_WIDTH-1:0] adc_word_t;

    // All four lanes as presented in one clock cycle
    // Index 0 is lane 0
    typedef struct packed {
        adc_word_t [NUM_LANES-1:0] lane;  // 56 bits
    } lane_words_t;

    // --------------------------------------------------
    // Deserialized frame
    // --------------------------------------------------
    // t[0] holds the oldest accepted word, t[3] the newest
    typedef struct packed {
        lane_words_t [WORDS_PER_FRAME-1:0] t;  // 224 bits, t0 to t3
        logic                              sync_seen; // Sync high at any accepting edge
    } adc_frame_t;

endpackage

`default_nettype wire
